/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  riscv_pkg::word_t   a_i,
    input  riscv_pkg::word_t   b_i,
    input  riscv_pkg::alu_op_e op_i,
    input  logic               sub_sra_i,
    input  logic               is_branch_i,
    output riscv_pkg::word_t   result_o,
    output logic               branch_cond_o
);
    import riscv_pkg::*;

    logic       eq, lt, ltu;
    logic [4:0] shamt;
    word_t      sra_res;
    logic       cond;

    assign eq    = (a_i == b_i);
    assign lt    = ($signed(a_i) < $signed(b_i));
    assign ltu   = (a_i < b_i);
    assign shamt = b_i[4:0];

    assign sra_res = $signed(a_i) >>> shamt;  // kept apart so it stays signed

    always_comb
    begin
        case (op_i)
            ALU_ADD:  result_o = sub_sra_i ? a_i - b_i : a_i + b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = {31'b0, lt};
            ALU_SLTU: result_o = {31'b0, ltu};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = sub_sra_i ? sra_res : a_i >> shamt;
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = '0;
        endcase
    end

    // branch funct3 reuses the op field
    always_comb
    begin
        case (br_cond_e'(op_i))
            BR_EQ:   cond = eq;
            BR_NE:   cond = !eq;
            BR_LT:   cond = lt;
            BR_GE:   cond = !lt;
            BR_LTU:  cond = ltu;
            BR_GEU:  cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign branch_cond_o = is_branch_i && cond;

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  riscv_pkg::word_t    pc_i,
    input  riscv_pkg::word_t    instr_i,
    output riscv_pkg::reg_idx_t rf_rs1_idx_o,
    output riscv_pkg::reg_idx_t rf_rs2_idx_o,
    output riscv_pkg::reg_idx_t id_rs1_idx_o,
    output riscv_pkg::reg_idx_t id_rs2_idx_o,
    output riscv_pkg::reg_idx_t id_rd_idx_o,
    output riscv_pkg::opcode_e  id_opcode_o,
    output logic [2:0]          id_funct3_o,
    output logic                id_sub_sra_o,
    output riscv_pkg::word_t    id_imm_o,
    output riscv_pkg::word_t    id_branch_target_o,
    output logic                id_rs1_used_o,
    output logic                id_rs2_used_o,
    output logic                id_reg_write_o
);
    import riscv_pkg::*;

    word_t imm_i, imm_s, imm_b;
    word_t imm;
    logic  legal, rs2_used, reg_write, sub_sra;

    assign rf_rs1_idx_o = instr_i[19:15];
    assign rf_rs2_idx_o = instr_i[24:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    always_comb
    begin
        legal     = 1'b1;
        rs2_used  = 1'b0;
        reg_write = 1'b0;
        sub_sra   = 1'b0;
        imm       = imm_i;
        case (instr_i[6:0])
            OPC_OP:
            begin
                rs2_used  = 1'b1;
                reg_write = 1'b1;
                sub_sra   = instr_i[30];
            end
            OPC_OP_IMM:
            begin
                reg_write = 1'b1;
                // only srai has the bit, addi must never subtract
                if (alu_op_e'(instr_i[14:12]) inside {ALU_SLL, ALU_SRL})
                begin
                    sub_sra = instr_i[30];
                end
            end
            OPC_LOAD:   reg_write = 1'b1;
            OPC_STORE:
            begin
                rs2_used = 1'b1;
                imm      = imm_s;
            end
            OPC_BRANCH:
            begin
                rs2_used = 1'b1;
                imm      = imm_b;
            end
            default:    legal = 1'b0;
        endcase
    end

    // ID/EX control, bubble looks like a nop that writes nothing
    always_ff @(posedge clk)
    begin
        if (!reset_i || stall_i || flush_i || !legal)
        begin
            id_opcode_o    <= OPC_OP_IMM;
            id_rd_idx_o    <= '0;
            id_reg_write_o <= 1'b0;
            id_rs1_used_o  <= 1'b0;
            id_rs2_used_o  <= 1'b0;
        end
        else
        begin
            id_opcode_o    <= opcode_e'(instr_i[6:0]);
            id_rd_idx_o    <= instr_i[11:7];
            id_reg_write_o <= reg_write;
            id_rs1_used_o  <= 1'b1;  // every kept opcode reads rs1
            id_rs2_used_o  <= rs2_used;
        end
    end

    always_ff @(posedge clk)
    begin
        id_rs1_idx_o       <= instr_i[19:15];
        id_rs2_idx_o       <= instr_i[24:20];
        id_funct3_o        <= instr_i[14:12];
        id_sub_sra_o       <= sub_sra;
        id_imm_o           <= imm;
        id_branch_target_o <= pc_i + imm_b;
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  riscv_pkg::reg_idx_t id_rd_idx_i,
    input  riscv_pkg::opcode_e  id_opcode_i,
    input  logic [2:0]          id_funct3_i,
    input  logic                id_sub_sra_i,
    input  riscv_pkg::word_t    id_imm_i,
    input  riscv_pkg::word_t    id_branch_target_i,
    input  logic                id_reg_write_i,
    input  riscv_pkg::word_t    rs1_data_i,
    input  riscv_pkg::word_t    rs2_data_i,
    input  riscv_pkg::fwd_sel_e fwd_rs1_sel_i,
    input  riscv_pkg::fwd_sel_e fwd_rs2_sel_i,
    input  riscv_pkg::word_t    wb_data_i,
    output logic                branch_taken_o,
    output riscv_pkg::word_t    branch_target_o,
    output riscv_pkg::word_t    ex_alu_result_o,
    output riscv_pkg::word_t    ex_store_data_o,
    output riscv_pkg::reg_idx_t ex_rd_idx_o,
    output logic                ex_reg_write_o,
    output logic                ex_mem_read_o,
    output logic                ex_mem_write_o
);
    import riscv_pkg::*;

    word_t   rs1_q, rs2_q;
    word_t   op_a, rs2_val, op_b, alu_res;
    alu_op_e alu_op;
    logic    is_mem, is_branch, use_imm, branch_cond;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    // register file data read in ID, data half of ID/EX
    always_ff @(posedge clk)
    begin
        rs1_q <= rs1_data_i;
        rs2_q <= rs2_data_i;
    end

    assign is_mem    = (id_opcode_i == OPC_LOAD) || (id_opcode_i == OPC_STORE);
    assign is_branch = (id_opcode_i == OPC_BRANCH);
    assign use_imm   = is_mem || (id_opcode_i == OPC_OP_IMM);

    assign op_a    = fwd_mux(fwd_rs1_sel_i, rs1_q, ex_alu_result_o, wb_data_i);
    assign rs2_val = fwd_mux(fwd_rs2_sel_i, rs2_q, ex_alu_result_o, wb_data_i);
    assign op_b    = use_imm ? id_imm_i : rs2_val;
    assign alu_op  = is_mem ? ALU_ADD : alu_op_e'(id_funct3_i);  // address add

    alu u_alu (
        .a_i           (op_a),
        .b_i           (op_b),
        .op_i          (alu_op),
        .sub_sra_i     (id_sub_sra_i && !is_mem),
        .is_branch_i   (is_branch),
        .result_o      (alu_res),
        .branch_cond_o (branch_cond)
    );

    assign branch_taken_o  = branch_cond;
    assign branch_target_o = id_branch_target_i;

    always_ff @(posedge clk)
    begin
        if (!reset_i)
        begin
            ex_rd_idx_o    <= '0;
            ex_reg_write_o <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
        end
        else
        begin
            ex_rd_idx_o    <= id_rd_idx_i;
            ex_reg_write_o <= id_reg_write_i;
            ex_mem_read_o  <= (id_opcode_i == OPC_LOAD);
            ex_mem_write_o <= (id_opcode_i == OPC_STORE);
        end
    end

    always_ff @(posedge clk)
    begin
        ex_alu_result_o <= alu_res;
        ex_store_data_o <= rs2_val;
    end

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             stall_i,
    input  logic             branch_taken_i,
    input  riscv_pkg::word_t branch_target_i,
    input  riscv_pkg::word_t imem_data_i,
    output riscv_pkg::word_t imem_addr_o,
    output riscv_pkg::word_t pc_o,
    output riscv_pkg::word_t instr_o
);
    import riscv_pkg::*;

    word_t pc_q;

    assign imem_addr_o = pc_q;  // combinational imem read

    always_ff @(posedge clk)
    begin
        if (!reset_i)
        begin
            pc_q    <= RESET_PC;
            instr_o <= NOP_INSTR;
        end
        else if (branch_taken_i)
        begin
            pc_q    <= branch_target_i;
            instr_o <= NOP_INSTR;  // wrong-path fetch dropped
        end
        else if (!stall_i)
        begin
            pc_q    <= pc_q + PC_STEP;
            instr_o <= imem_data_i;
        end
    end

    // address of the word in IF/ID, only used for branch targets
    always_ff @(posedge clk)
    begin
        if (!stall_i)
        begin
            pc_o <= pc_q;
        end
    end

endmodule

/* hdl/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  riscv_pkg::reg_idx_t id_rs1_idx_i,
    input  riscv_pkg::reg_idx_t id_rs2_idx_i,
    input  logic                id_rs1_used_i,
    input  logic                id_rs2_used_i,
    input  riscv_pkg::opcode_e  id_opcode_i,
    input  riscv_pkg::reg_idx_t id_rd_idx_i,
    input  riscv_pkg::word_t    if_instr_i,
    input  riscv_pkg::reg_idx_t ex_rd_idx_i,
    input  logic                ex_reg_write_i,
    input  logic                ex_mem_read_i,
    input  riscv_pkg::reg_idx_t wb_rd_idx_i,
    input  logic                wb_we_i,
    output riscv_pkg::fwd_sel_e fwd_rs1_sel_o,
    output riscv_pkg::fwd_sel_e fwd_rs2_sel_o,
    output logic                stall_o
);
    import riscv_pkg::*;

    logic     mem_fwd_ok, wb_fwd_ok;
    logic     if_uses_rs1, if_uses_rs2;
    reg_idx_t if_rs1, if_rs2;
    logic [6:0] if_opc;

    // a load in EX/MEM has no data yet, the interlock covers it
    assign mem_fwd_ok = ex_reg_write_i && !ex_mem_read_i && (ex_rd_idx_i != '0);
    assign wb_fwd_ok  = wb_we_i && (wb_rd_idx_i != '0);

    always_comb
    begin
        fwd_rs1_sel_o = FWD_NONE;
        fwd_rs2_sel_o = FWD_NONE;
        if (id_rs1_used_i && mem_fwd_ok && ex_rd_idx_i == id_rs1_idx_i)
            fwd_rs1_sel_o = FWD_MEM;
        else if (id_rs1_used_i && wb_fwd_ok && wb_rd_idx_i == id_rs1_idx_i)
            fwd_rs1_sel_o = FWD_WB;
        if (id_rs2_used_i && mem_fwd_ok && ex_rd_idx_i == id_rs2_idx_i)
            fwd_rs2_sel_o = FWD_MEM;
        else if (id_rs2_used_i && wb_fwd_ok && wb_rd_idx_i == id_rs2_idx_i)
            fwd_rs2_sel_o = FWD_WB;
    end

    assign if_opc = if_instr_i[6:0];
    assign if_rs1 = if_instr_i[19:15];
    assign if_rs2 = if_instr_i[24:20];

    assign if_uses_rs2 = (if_opc == OPC_OP) || (if_opc == OPC_STORE) || (if_opc == OPC_BRANCH);
    assign if_uses_rs1 = if_uses_rs2 || (if_opc == OPC_OP_IMM) || (if_opc == OPC_LOAD);

    // load in ID/EX feeding the word in IF/ID
    assign stall_o = (id_opcode_i == OPC_LOAD) && (id_rd_idx_i != '0) &&
                     ((if_uses_rs1 && if_rs1 == id_rd_idx_i) ||
                      (if_uses_rs2 && if_rs2 == id_rd_idx_i));

endmodule

/* hdl/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  riscv_pkg::word_t    ex_alu_result_i,
    input  riscv_pkg::word_t    ex_store_data_i,
    input  riscv_pkg::reg_idx_t ex_rd_idx_i,
    input  logic                ex_reg_write_i,
    input  logic                ex_mem_read_i,
    input  logic                ex_mem_write_i,
    input  riscv_pkg::word_t    dmem_rdata_i,
    output riscv_pkg::word_t    dmem_addr_o,
    output riscv_pkg::word_t    dmem_wdata_o,
    output logic                dmem_we_o,
    output logic                dmem_re_o,
    output logic                wb_we_o,
    output riscv_pkg::reg_idx_t wb_rd_idx_o,
    output riscv_pkg::word_t    wb_data_o
);
    import riscv_pkg::*;

    word_t alu_result_q;
    logic  is_load_q;

    assign dmem_addr_o  = ex_alu_result_i;
    assign dmem_wdata_o = ex_store_data_i;
    assign dmem_we_o    = ex_mem_write_i;
    assign dmem_re_o    = ex_mem_read_i;

    always_ff @(posedge clk)
    begin
        if (!reset_i)
        begin
            wb_we_o     <= 1'b0;
            wb_rd_idx_o <= '0;
            is_load_q   <= 1'b0;
        end
        else
        begin
            wb_we_o     <= ex_reg_write_i;
            wb_rd_idx_o <= ex_rd_idx_i;
            is_load_q   <= ex_mem_read_i;
        end
    end

    always_ff @(posedge clk)
    begin
        alu_result_q <= ex_alu_result_i;
    end

    assign wb_data_o = is_load_q ? dmem_rdata_i : alu_result_q;  // read data lands here

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                we_i,
    input  riscv_pkg::reg_idx_t rd_idx_i,
    input  riscv_pkg::word_t    rd_data_i,
    input  riscv_pkg::reg_idx_t rs1_idx_i,
    input  riscv_pkg::reg_idx_t rs2_idx_i,
    output riscv_pkg::word_t    rs1_data_o,
    output riscv_pkg::word_t    rs2_data_o
);
    import riscv_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_en;

    assign wr_en = reset_i && we_i && (rd_idx_i != '0);  // x0 never written

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            regs[rd_idx_i] <= rd_data_i;
        end
    end

    // write-first, so a writeback in this cycle is seen by decode
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 :
                        (wr_en && rd_idx_i == rs1_idx_i) ? rd_data_i : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 :
                        (wr_en && rd_idx_i == rs2_idx_i) ? rd_data_i : regs[rs2_idx_i];

endmodule

/* hdl/riscv_core.sv */
`timescale 1ns/1ps

module riscv_core (
    input  logic             clk,
    input  logic             reset_i,
    input  riscv_pkg::word_t imem_data_i,
    input  riscv_pkg::word_t dmem_rdata_i,
    output riscv_pkg::word_t imem_addr_o,
    output riscv_pkg::word_t dmem_addr_o,
    output riscv_pkg::word_t dmem_wdata_o,
    output logic             dmem_we_o,
    output logic             dmem_re_o
);
    import riscv_pkg::*;

    word_t    if_pc, if_instr;
    reg_idx_t rf_rs1_idx, rf_rs2_idx;
    word_t    rf_rs1_data, rf_rs2_data;
    reg_idx_t id_rs1_idx, id_rs2_idx, id_rd_idx;
    opcode_e  id_opcode;
    logic [2:0] id_funct3;
    logic     id_sub_sra, id_rs1_used, id_rs2_used, id_reg_write;
    word_t    id_imm, id_branch_target;
    logic     branch_taken, stall;
    word_t    branch_target;
    fwd_sel_e fwd_rs1_sel, fwd_rs2_sel;
    word_t    ex_alu_result, ex_store_data;
    reg_idx_t ex_rd_idx;
    logic     ex_reg_write, ex_mem_read, ex_mem_write;
    logic     wb_we;
    reg_idx_t wb_rd_idx;
    word_t    wb_data;

    fetch_stage u_fetch (
        .clk (clk), .reset_i (reset_i), .stall_i (stall),
        .branch_taken_i (branch_taken), .branch_target_i (branch_target),
        .imem_data_i (imem_data_i), .imem_addr_o (imem_addr_o),
        .pc_o (if_pc), .instr_o (if_instr)
    );

    decode_stage u_decode (
        .clk (clk), .reset_i (reset_i), .stall_i (stall), .flush_i (branch_taken),
        .pc_i (if_pc), .instr_i (if_instr),
        .rf_rs1_idx_o (rf_rs1_idx), .rf_rs2_idx_o (rf_rs2_idx),
        .id_rs1_idx_o (id_rs1_idx), .id_rs2_idx_o (id_rs2_idx), .id_rd_idx_o (id_rd_idx),
        .id_opcode_o (id_opcode), .id_funct3_o (id_funct3), .id_sub_sra_o (id_sub_sra),
        .id_imm_o (id_imm), .id_branch_target_o (id_branch_target),
        .id_rs1_used_o (id_rs1_used), .id_rs2_used_o (id_rs2_used),
        .id_reg_write_o (id_reg_write)
    );

    register_file u_regfile (
        .clk (clk), .reset_i (reset_i),
        .we_i (wb_we), .rd_idx_i (wb_rd_idx), .rd_data_i (wb_data),
        .rs1_idx_i (rf_rs1_idx), .rs2_idx_i (rf_rs2_idx),
        .rs1_data_o (rf_rs1_data), .rs2_data_o (rf_rs2_data)
    );

    execute_stage u_execute (
        .clk (clk), .reset_i (reset_i),
        .id_rd_idx_i (id_rd_idx), .id_opcode_i (id_opcode), .id_funct3_i (id_funct3),
        .id_sub_sra_i (id_sub_sra), .id_imm_i (id_imm),
        .id_branch_target_i (id_branch_target), .id_reg_write_i (id_reg_write),
        .rs1_data_i (rf_rs1_data), .rs2_data_i (rf_rs2_data),
        .fwd_rs1_sel_i (fwd_rs1_sel), .fwd_rs2_sel_i (fwd_rs2_sel), .wb_data_i (wb_data),
        .branch_taken_o (branch_taken), .branch_target_o (branch_target),
        .ex_alu_result_o (ex_alu_result), .ex_store_data_o (ex_store_data),
        .ex_rd_idx_o (ex_rd_idx), .ex_reg_write_o (ex_reg_write),
        .ex_mem_read_o (ex_mem_read), .ex_mem_write_o (ex_mem_write)
    );

    hazard_unit u_hazard (
        .id_rs1_idx_i (id_rs1_idx), .id_rs2_idx_i (id_rs2_idx),
        .id_rs1_used_i (id_rs1_used), .id_rs2_used_i (id_rs2_used),
        .id_opcode_i (id_opcode), .id_rd_idx_i (id_rd_idx), .if_instr_i (if_instr),
        .ex_rd_idx_i (ex_rd_idx), .ex_reg_write_i (ex_reg_write),
        .ex_mem_read_i (ex_mem_read), .wb_rd_idx_i (wb_rd_idx), .wb_we_i (wb_we),
        .fwd_rs1_sel_o (fwd_rs1_sel), .fwd_rs2_sel_o (fwd_rs2_sel), .stall_o (stall)
    );

    mem_wb_stage u_mem_wb (
        .clk (clk), .reset_i (reset_i),
        .ex_alu_result_i (ex_alu_result), .ex_store_data_i (ex_store_data),
        .ex_rd_idx_i (ex_rd_idx), .ex_reg_write_i (ex_reg_write),
        .ex_mem_read_i (ex_mem_read), .ex_mem_write_i (ex_mem_write),
        .dmem_rdata_i (dmem_rdata_i), .dmem_addr_o (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o), .dmem_we_o (dmem_we_o), .dmem_re_o (dmem_re_o),
        .wb_we_o (wb_we), .wb_rd_idx_o (wb_rd_idx), .wb_data_o (wb_data)
    );

endmodule

/* hdl/riscv_pkg.sv */
package riscv_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam word_t PC_STEP   = 32'd4;
    localparam word_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 of OP / OP-IMM
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SRL  = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_e;

    // funct3 of BRANCH
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_e;

endpackage

/* riscv_core.f */
hdl/riscv_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/alu.sv
hdl/execute_stage.sv
hdl/hazard_unit.sv
hdl/mem_wb_stage.sv
hdl/riscv_core.sv
testbench/riscv_core_assertions.sv
testbench/riscv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, verdict comes from the simulation log
verilator --binary --assert -j 0 --top-module riscv_core_tb -f riscv_core.f \
    -o riscv_core_sim > build.log 2>&1 \
    && ./obj_dir/riscv_core_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0

/* testbench/riscv_core_assertions.sv */
`timescale 1ns/1ps

module riscv_core_assertions (
    input logic        clk,
    input logic        reset_i,
    input logic [31:0] imem_addr_o,
    input logic        dmem_we_o,
    input logic        dmem_re_o
);

    a_no_rw_overlap: assert property (@(posedge clk) !(dmem_we_o && dmem_re_o))
        else $error("data memory read and write in the same cycle");

    a_fetch_aligned: assert property (@(posedge clk) reset_i |-> imem_addr_o[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // memory port quiet once reset has been seen
    a_reset_quiet: assert property (@(posedge clk) !reset_i |=> (!dmem_we_o && !dmem_re_o))
        else $error("data memory access right after reset");

endmodule

bind riscv_core riscv_core_assertions u_assertions (
    .clk         (clk),
    .reset_i     (reset_i),
    .imem_addr_o (imem_addr_o),
    .dmem_we_o   (dmem_we_o),
    .dmem_re_o   (dmem_re_o)
);

/* testbench/riscv_core_tb.sv */
`timescale 1ns/1ps

module riscv_core_tb;
    import riscv_pkg::*;

    logic  clk;
    logic  reset_i;
    word_t imem_data, dmem_rdata;
    word_t imem_addr, dmem_addr, dmem_wdata;
    logic  dmem_we, dmem_re;

    word_t  imem [256];
    word_t  dmem [256];
    word_t  prog[$];
    word_t  exp_addr[$], exp_data[$], st_addr[$], st_data[$];
    integer seed = 10;
    integer errors = 0;
    integer tests_run = 0;
    integer tests_failed = 0;

    riscv_core uut (
        .clk (clk), .reset_i (reset_i),
        .imem_data_i (imem_data), .dmem_rdata_i (dmem_rdata),
        .imem_addr_o (imem_addr), .dmem_addr_o (dmem_addr),
        .dmem_wdata_o (dmem_wdata), .dmem_we_o (dmem_we), .dmem_re_o (dmem_re)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    assign imem_data = imem[imem_addr[9:2]];  // combinational fetch

    always @(posedge clk)
    begin
        if (dmem_re)
            dmem_rdata <= dmem[dmem_addr[9:2]];
        if (dmem_we)
        begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
            st_addr.push_back(dmem_addr);
            st_data.push_back(dmem_wdata);
        end
    end

    function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // RV32I result by the ISA rules
    function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
        logic [4:0] s;
        s = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << s;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return (a >> s) | ((alt && a[31]) ? ~(32'hffff_ffff >> s) : 32'd0);
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t fill_word(int i);
        return (32'h9e37_79b9 * (i + 1)) ^ {i[7:0], 24'h0};
    endfunction

    // 32-bit constant built from addi, slli and ori
    task automatic load_const(input logic [4:0] rd, input word_t v);
        prog.push_back(i_type({2'b0, v[31:22]}, 5'd0, 3'b000, rd, OPC_OP_IMM));
        prog.push_back(i_type(12'd11, rd, 3'b001, rd, OPC_OP_IMM));
        prog.push_back(i_type({1'b0, v[21:11]}, rd, 3'b110, rd, OPC_OP_IMM));
        prog.push_back(i_type(12'd11, rd, 3'b001, rd, OPC_OP_IMM));
        prog.push_back(i_type({1'b0, v[10:0]}, rd, 3'b110, rd, OPC_OP_IMM));
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic hold_reset();
        @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        st_addr.delete();
        st_data.delete();
    endtask

    // loads prog, runs it from reset and compares the store log
    task automatic run_program(input string name);
        integer cycles;
        word_t  end_addr;
        hold_reset();
        for (int i = 0; i < 256; i++)
        begin
            imem[i] = i_type({4'b0, i[7:0]}, 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
            dmem[i] = fill_word(i);
        end
        foreach (prog[i])
            imem[i] = prog[i];
        repeat (4) @(posedge clk);
        reset_i <= 1'b1;
        end_addr = 4 * (prog.size() + 6);
        cycles = 0;
        while (st_data.size() < exp_data.size() && cycles < 1000)
        begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        while (imem_addr < end_addr && cycles < 1000)
        begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        @(negedge clk);
        if (cycles >= 1000)
        begin
            $display("%s: timed out waiting for the program to finish", name);
            errors = errors + 1;
        end
        if (st_data.size() != exp_data.size())
        begin
            $display("%s: expected %0d stores but saw %0d", name, exp_data.size(),
                     st_data.size());
            errors = errors + 1;
        end
        for (int i = 0; i < exp_data.size() && i < st_data.size(); i++)
        begin
            check_word({name, " addr"}, exp_addr[i], st_addr[i]);
            check_word({name, " data"}, exp_data[i], st_data[i]);
        end
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic report(input string name, input integer errs_before);
        tests_run = tests_run + 1;
        if (errors == errs_before)
            $display("test %s: pass", name);
        else
        begin
            $display("test %s: FAIL with %0d errors", name, errors - errs_before);
            tests_failed = tests_failed + 1;
        end
    endtask

    task automatic reset_test();
        integer e0;
        e0 = errors;
        for (int i = 0; i < 256; i++)
            imem[i] = s_type({2'b0, i[7:0], 2'b0}, 5'd0, 5'd0);  // a store at every word
        hold_reset();
        repeat (4)
        begin
            @(negedge clk);
            check_word("reset pc", RESET_PC, imem_addr);
            check_word("reset stores", 32'd0, st_data.size());
            @(posedge clk);
        end
        reset_i <= 1'b1;
        @(negedge clk);
        check_word("first pc", RESET_PC, imem_addr);
        check_word("first we", 32'd0, {31'd0, dmem_we});
        check_word("first re", 32'd0, {31'd0, dmem_re});
        check_word("first stores", 32'd0, st_data.size());
        @(posedge clk);
        reset_i <= 1'b0;  // back in reset before the first store reaches memory
        report("reset", e0);
    endtask

    task automatic alu_test();
        integer e0;
        word_t  a, b, imm;
        logic [2:0] rf3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        logic       ralt[10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        logic [2:0] if3 [9]  = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
        logic       ialt[9]  = '{0, 0, 0, 0, 0, 0, 0, 0, 1};
        e0 = errors;
        a = $random(seed);
        b = $random(seed);
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 10; k++)
        begin
            prog.push_back(r_type(ralt[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, rf3[k], 5'd3));
            prog.push_back(s_type(12'h100 + 4 * k, 5'd3, 5'd0));
            expect_store(32'h100 + 4 * k, ref_alu(rf3[k], ralt[k], a, b));
        end
        for (int k = 0; k < 9; k++)
        begin
            imm = {{20{1'b0}}, 12'($random(seed))};
            if (if3[k] == 3'd1 || if3[k] == 3'd5)
                imm[11:5] = ialt[k] ? 7'h20 : 7'h00;  // shamt form
            prog.push_back(i_type(imm[11:0], 5'd1, if3[k], 5'd4, OPC_OP_IMM));
            prog.push_back(s_type(12'h180 + 4 * k, 5'd4, 5'd0));
            expect_store(32'h180 + 4 * k,
                         ref_alu(if3[k], ialt[k], a, {{20{imm[11]}}, imm[11:0]}));
        end
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));  // x0 stays zero
        prog.push_back(s_type(12'h1f0, 5'd0, 5'd0));
        expect_store(32'h1f0, 32'd0);
        run_program("alu");
        report("alu", e0);
    endtask

    task automatic forward_test();
        integer e0;
        word_t  a, b, x3, x4, x5, x6;
        e0 = errors;
        a = $random(seed);
        b = $random(seed);
        x3 = ref_alu(3'd0, 1'b0, a, b);
        x4 = ref_alu(3'd0, 1'b1, x3, a);
        x5 = ref_alu(3'd4, 1'b0, x3, x4);
        x6 = ref_alu(3'd6, 1'b0, x3, x5);
        load_const(5'd1, a);
        load_const(5'd2, b);
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        prog.push_back(r_type(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));  // distance one
        prog.push_back(r_type(7'h00, 5'd4, 5'd3, 3'd4, 5'd5));  // distance two
        prog.push_back(r_type(7'h00, 5'd5, 5'd3, 3'd6, 5'd6));  // distance three
        prog.push_back(s_type(12'h300, 5'd6, 5'd0));
        prog.push_back(s_type(12'h304, 5'd5, 5'd0));
        prog.push_back(s_type(12'h308, 5'd4, 5'd0));
        prog.push_back(s_type(12'h30c, 5'd3, 5'd0));
        expect_store(32'h300, x6);
        expect_store(32'h304, x5);
        expect_store(32'h308, x4);
        expect_store(32'h30c, x3);
        run_program("forward");
        report("forward", e0);
    endtask

    task automatic load_test();
        integer e0;
        word_t  a;
        e0 = errors;
        a = $random(seed);
        load_const(5'd1, a);
        prog.push_back(s_type(12'h040, 5'd1, 5'd0));
        prog.push_back(i_type(12'h040, 5'd0, 3'b010, 5'd2, OPC_LOAD));
        prog.push_back(r_type(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));  // load-use
        prog.push_back(s_type(12'h044, 5'd3, 5'd0));
        prog.push_back(i_type(12'h080, 5'd0, 3'b010, 5'd4, OPC_LOAD));
        prog.push_back(s_type(12'h048, 5'd4, 5'd0));
        expect_store(32'h040, a);
        expect_store(32'h044, a + a);
        expect_store(32'h048, fill_word(32'h080 >> 2));
        run_program("load");
        report("load", e0);
    endtask

    task automatic branch_test();
        integer e0;
        word_t  p, n;
        word_t  ops_a[3], ops_b[3];
        logic [2:0] f3s[6] = '{0, 1, 4, 5, 6, 7};
        e0 = errors;
        p = $random(seed) & 32'h7fff_ffff;
        n = $random(seed) | 32'h8000_0000;
        ops_a = '{p, n, p};
        ops_b = '{n, p, p};
        for (int c = 0; c < 6; c++)
        begin
            for (int k = 0; k < 3; k++)
            begin
                load_const(5'd1, ops_a[k]);
                load_const(5'd2, ops_b[k]);
                prog.push_back(i_type(12'h111, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
                prog.push_back(i_type(12'h222, 5'd0, 3'b000, 5'd4, OPC_OP_IMM));
                prog.push_back(b_type(13'd12, 5'd2, 5'd1, f3s[c]));
                prog.push_back(s_type(12'h200, 5'd3, 5'd0));  // shadow slots
                prog.push_back(s_type(12'h204, 5'd3, 5'd0));
                prog.push_back(s_type(12'h208, 5'd4, 5'd0));
                if (!ref_branch(f3s[c], ops_a[k], ops_b[k]))
                begin
                    expect_store(32'h200, 32'h111);
                    expect_store(32'h204, 32'h111);
                end
                expect_store(32'h208, 32'h222);
                run_program($sformatf("branch f3=%0d pair=%0d", f3s[c], k));
            end
        end
        report("branch", e0);
    endtask

    initial
    begin
        reset_i    = 1'b0;
        dmem_rdata = '0;
        for (int i = 0; i < 256; i++)
        begin
            imem[i] = i_type({4'b0, i[7:0]}, 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
            dmem[i] = fill_word(i);
        end
        repeat (5) @(posedge clk);
        reset_test();
        alu_test();
        forward_test();
        load_test();
        branch_test();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
